/* all.f */
+incdir+hdl
hdl/cube_pkg.sv
hdl/video_timing.sv
hdl/scene_sequencer.sv
hdl/pixel_color.sv
hdl/cube_demo_top.sv
test/tb_cube_demo.sv

/* hdl/cube_defs.svh */
// ##################################################
// timing, colour and schedule constants of the VGA demo
// include where a module defaults its parameters
// ##################################################

`ifndef CUBE_DEFS_SVH
`define CUBE_DEFS_SVH

// horizontal, already doubled for the 2x pixel clock
`define CUBE_H_ACTIVE 1280
`define CUBE_H_FRONT  32
`define CUBE_H_SYNC   192
`define CUBE_H_BACK   96

// vertical, in lines
`define CUBE_V_ACTIVE 480
`define CUBE_V_FRONT  10
`define CUBE_V_SYNC   2
`define CUBE_V_BACK   33

// lines per pixel row, a column is twice as many clocks
`define CUBE_DIVIDE 6

// one schedule step lasts 2**STEP_BITS frames
`define CUBE_STEP_BITS 6

`define CUBE_COLOR_BLACK 6'h00
`define CUBE_COLOR_WHITE 6'h3F

// rainbow stripes
`define CUBE_COLOR_1 6'h31 // pink
`define CUBE_COLOR_2 6'h15
`define CUBE_COLOR_3 6'h0C // green
`define CUBE_COLOR_4 6'h2C

`endif

/* hdl/cube_demo_top.sv */
// ##################################################
// VGA demo top, timing, schedule and colour stage to the pins
// ##################################################

`include "cube_defs.svh"

module cube_demo_top #(
    parameter int unsigned H_ACTIVE  = `CUBE_H_ACTIVE,
    parameter int unsigned H_FRONT   = `CUBE_H_FRONT,
    parameter int unsigned H_SYNC    = `CUBE_H_SYNC,
    parameter int unsigned H_BACK    = `CUBE_H_BACK,
    parameter int unsigned V_ACTIVE  = `CUBE_V_ACTIVE,
    parameter int unsigned V_FRONT   = `CUBE_V_FRONT,
    parameter int unsigned V_SYNC    = `CUBE_V_SYNC,
    parameter int unsigned V_BACK    = `CUBE_V_BACK,
    parameter int unsigned STEP_BITS = `CUBE_STEP_BITS,
    parameter int unsigned DIVIDE    = `CUBE_DIVIDE
) (
    input  logic           clk_i,  // 2x pixel clock
    input  logic           rst_ni,
    output cube_pkg::rgb_t rrggbb_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           next_vertical_o,
    output logic           next_frame_o
);

    cube_pkg::beam_t    beam;
    cube_pkg::frame_t   frame;
    cube_pkg::fill_t    fill;
    cube_pkg::vga_out_t vga;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) timing_i (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .beam_o (beam)
    );

    scene_sequencer #(
        .STEP_BITS (STEP_BITS)
    ) sequencer_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .beam_i  (beam),
        .frame_o (frame),
        .fill_o  (fill)
    );

    pixel_color #(
        .DIVIDE (DIVIDE)
    ) color_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .beam_i  (beam),
        .frame_i (frame),
        .fill_i  (fill),
        .vga_o   (vga)
    );

    assign rrggbb_o        = vga.rrggbb;
    assign hsync_o         = vga.hsync;
    assign vsync_o         = vga.vsync;
    assign next_vertical_o = vga.next_vertical;
    assign next_frame_o    = vga.next_frame;

endmodule

/* hdl/cube_pkg.sv */
// ##################################################
// shared types of the VGA demo, used by scoped name
// ##################################################

package cube_pkg;

    typedef logic [11:0] cnt_t;   // beam counter
    typedef logic [7:0]  pixel_t; // divided coordinate
    typedef logic [15:0] frame_t;
    typedef logic [5:0]  rgb_t;   // RRGGBB

    // fill shown over the active area
    typedef enum logic [1:0] {
        FILL_BLACK,
        FILL_WHITE,
        FILL_STRIPES,
        FILL_XOR
    } fill_t;

    // beam state, combinational from the counters
    typedef struct packed {
        cnt_t h_count;
        cnt_t v_count;
        logic hblank;
        logic vblank;
        logic hsync;     // active low
        logic vsync;     // active low
        logic line_end;
        logic frame_end;
    } beam_t;

    // registered pin values
    typedef struct packed {
        rgb_t rrggbb;
        logic hsync;
        logic vsync;
        logic next_vertical;
        logic next_frame;
    } vga_out_t;

endpackage

/* hdl/pixel_color.sv */
// ##################################################
// pattern colour per pixel, black in blanking
// registers colour, syncs and strobes with one cycle latency
// ##################################################

`include "cube_defs.svh"

module pixel_color #(
    parameter int unsigned DIVIDE = `CUBE_DIVIDE
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  cube_pkg::beam_t    beam_i,
    input  cube_pkg::frame_t   frame_i,
    input  cube_pkg::fill_t    fill_i,
    output cube_pkg::vga_out_t vga_o
);

    localparam int unsigned SUB_H_W = $clog2(2 * DIVIDE);
    localparam int unsigned SUB_V_W = $clog2(DIVIDE + 1);

    logic [SUB_H_W-1:0] sub_h;
    logic [SUB_V_W-1:0] sub_v;
    cube_pkg::pixel_t   px;
    cube_pkg::pixel_t   py;

    logic [1:0]         stripe_idx;
    cube_pkg::rgb_t     stripe_color;
    cube_pkg::rgb_t     xor_color;
    cube_pkg::rgb_t     fill_color;
    cube_pkg::vga_out_t vga_d;
    cube_pkg::vga_out_t vga_q;

    // px and py follow the current beam position
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            sub_h <= '0;
            sub_v <= '0;
            px    <= '0;
            py    <= '0;
        end else begin
            if (beam_i.line_end) begin
                sub_h <= '0;
                px    <= '0;
                if (beam_i.frame_end) begin
                    sub_v <= '0;
                    py    <= '0;
                end else if (sub_v == SUB_V_W'(DIVIDE - 1)) begin
                    sub_v <= '0;
                    py    <= py + 1'b1;
                end else begin
                    sub_v <= sub_v + 1'b1;
                end
            end else if (sub_h == SUB_H_W'(2 * DIVIDE - 1)) begin
                sub_h <= '0;
                px    <= px + 1'b1;
            end else begin
                sub_h <= sub_h + 1'b1;
            end
        end
    end

    assign stripe_idx = py[1:0] + frame_i[2:1]; // rows scroll with time

    always_comb begin
        case (stripe_idx)
            2'd0:    stripe_color = `CUBE_COLOR_1;
            2'd1:    stripe_color = `CUBE_COLOR_2;
            2'd2:    stripe_color = `CUBE_COLOR_3;
            default: stripe_color = `CUBE_COLOR_4;
        endcase
    end

    assign xor_color = (px[5:0] ^ py[5:0]) + frame_i[7:2];

    always_comb begin
        case (fill_i)
            cube_pkg::FILL_WHITE:   fill_color = `CUBE_COLOR_WHITE;
            cube_pkg::FILL_STRIPES: fill_color = stripe_color;
            cube_pkg::FILL_XOR:     fill_color = xor_color;
            default:                fill_color = `CUBE_COLOR_BLACK;
        endcase
    end

    always_comb begin
        vga_d.rrggbb        = (beam_i.hblank || beam_i.vblank) ? `CUBE_COLOR_BLACK : fill_color;
        vga_d.hsync         = beam_i.hsync;
        vga_d.vsync         = beam_i.vsync;
        vga_d.next_vertical = beam_i.line_end;
        vga_d.next_frame    = beam_i.frame_end;
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            vga_q <= '0;
        end else begin
            vga_q <= vga_d;
        end
    end

    assign vga_o = vga_q;

    // column counter agrees with the divided beam counter
    column_tracks_beam: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cube_pkg::cnt_t'(px) == beam_i.h_count / cube_pkg::cnt_t'(2 * DIVIDE)
    );

endmodule

/* hdl/scene_sequencer.sv */
// ##################################################
// frame counter and scene schedule for the demo
// picks the fill that the colour stage paints
// ##################################################

`include "cube_defs.svh"

module scene_sequencer #(
    parameter int unsigned STEP_BITS = `CUBE_STEP_BITS
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  cube_pkg::beam_t  beam_i,
    output cube_pkg::frame_t frame_o,
    output cube_pkg::fill_t  fill_o
);

    cube_pkg::frame_t frame_cnt;
    logic [5:0]       step;
    cube_pkg::fill_t  fill;

    // animation time base
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            frame_cnt <= '0;
        end else if (beam_i.frame_end) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign step = frame_cnt[STEP_BITS +: 6]; // 64 steps per pass

    // schedule of the full-screen fill
    always_comb begin
        case (step) inside
            [6'd0:6'd3],
            [6'd28:6'd31]: begin
                fill = cube_pkg::FILL_BLACK;
            end
            [6'd4:6'd19],
            [6'd32:6'd53]: begin
                fill = cube_pkg::FILL_WHITE;
            end
            [6'd20:6'd23],
            [6'd54:6'd57],
            [6'd62:6'd63]: begin
                fill = cube_pkg::FILL_STRIPES;
            end
            [6'd24:6'd27],
            [6'd58:6'd61]: begin
                fill = cube_pkg::FILL_XOR;
            end
            default: begin
                fill = cube_pkg::FILL_BLACK;
            end
        endcase
    end

    assign frame_o = frame_cnt;
    assign fill_o  = fill;

    // the colour stage must always see a defined fill
    fill_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(fill_o)
    );

endmodule

/* hdl/video_timing.sv */
// ##################################################
// beam counters for 640x480 at twice the pixel clock
// gives blanking, active-low syncs and line/frame strobes
// ##################################################

`include "cube_defs.svh"

module video_timing #(
    parameter int unsigned H_ACTIVE = `CUBE_H_ACTIVE,
    parameter int unsigned H_FRONT  = `CUBE_H_FRONT,
    parameter int unsigned H_SYNC   = `CUBE_H_SYNC,
    parameter int unsigned H_BACK   = `CUBE_H_BACK,
    parameter int unsigned V_ACTIVE = `CUBE_V_ACTIVE,
    parameter int unsigned V_FRONT  = `CUBE_V_FRONT,
    parameter int unsigned V_SYNC   = `CUBE_V_SYNC,
    parameter int unsigned V_BACK   = `CUBE_V_BACK
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    output cube_pkg::beam_t beam_o
);

    localparam int unsigned H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int unsigned H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int unsigned H_TOTAL      = H_SYNC_END + H_BACK;

    localparam int unsigned V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int unsigned V_SYNC_END   = V_SYNC_START + V_SYNC;
    localparam int unsigned V_TOTAL      = V_SYNC_END + V_BACK;

    cube_pkg::cnt_t h_cnt;
    cube_pkg::cnt_t v_cnt;
    logic           line_end;
    logic           frame_end;

    assign line_end  = (h_cnt == cube_pkg::cnt_t'(H_TOTAL - 1));
    assign frame_end = line_end && (v_cnt == cube_pkg::cnt_t'(V_TOTAL - 1));

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (frame_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1; // one step per line
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // active area first, then front porch, sync, back porch
    always_comb begin
        beam_o.h_count   = h_cnt;
        beam_o.v_count   = v_cnt;
        beam_o.hblank    = (h_cnt >= cube_pkg::cnt_t'(H_ACTIVE));
        beam_o.vblank    = (v_cnt >= cube_pkg::cnt_t'(V_ACTIVE));
        beam_o.hsync     = !((h_cnt >= cube_pkg::cnt_t'(H_SYNC_START)) &&
                             (h_cnt <  cube_pkg::cnt_t'(H_SYNC_END)));
        beam_o.vsync     = !((v_cnt >= cube_pkg::cnt_t'(V_SYNC_START)) &&
                             (v_cnt <  cube_pkg::cnt_t'(V_SYNC_END)));
        beam_o.line_end  = line_end;
        beam_o.frame_end = frame_end;
    end

    // counters never leave the frame
    counters_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (h_cnt < cube_pkg::cnt_t'(H_TOTAL)) && (v_cnt < cube_pkg::cnt_t'(V_TOTAL))
    );

    // a frame ends on a line end and the beam restarts at the origin
    frame_wraps: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        beam_o.frame_end |-> beam_o.line_end ##1 (h_cnt == '0 && v_cnt == '0)
    );

endmodule

/* test/tb_cube_demo.sv */
// ##################################################
// testbench of the VGA demo top on a small 32x15 frame
// every output cycle is compared with a reference model
// ##################################################

module tb_cube_demo;

    localparam int H_ACT = 24;
    localparam int H_FP  = 2;
    localparam int H_SY  = 4;
    localparam int H_BP  = 2;
    localparam int V_ACT = 12;
    localparam int V_FP  = 1;
    localparam int V_SY  = 1;
    localparam int V_BP  = 1;
    localparam int DIV   = 6;
    localparam int STEP  = 1;

    localparam int H_TOT         = H_ACT + H_FP + H_SY + H_BP;
    localparam int V_TOT         = V_ACT + V_FP + V_SY + V_BP;
    localparam int FRAME_CYCLES  = H_TOT * V_TOT; // 480
    localparam int RUN_FRAMES    = 130;
    localparam int WATCHDOG_TIME = 135 * FRAME_CYCLES * 20;

    logic               clk_i;
    logic               rst_ni;
    cube_pkg::rgb_t     rrggbb_o;
    logic               hsync_o;
    logic               vsync_o;
    logic               next_vertical_o;
    logic               next_frame_o;

    // reference model state
    int                 m_h;
    int                 m_v;
    cube_pkg::frame_t   m_frame;
    cube_pkg::vga_out_t exp_q;
    cube_pkg::fill_t    exp_fill;
    logic               exp_blank;
    logic [3:0]         fills_seen = '0;

    int                 errors [1:5];
    int                 n_checks;

    cube_demo_top #(
        .H_ACTIVE (H_ACT), .H_FRONT (H_FP), .H_SYNC (H_SY), .H_BACK (H_BP),
        .V_ACTIVE (V_ACT), .V_FRONT (V_FP), .V_SYNC (V_SY), .V_BACK (V_BP),
        .STEP_BITS (STEP),
        .DIVIDE    (DIV)
    ) dut_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .rrggbb_o        (rrggbb_o),
        .hsync_o         (hsync_o),
        .vsync_o         (vsync_o),
        .next_vertical_o (next_vertical_o),
        .next_frame_o    (next_frame_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        rst_ni = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout, the run did not end within %0d time units", WATCHDOG_TIME);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic string behavior_text(input int b);
        case (b)
            1:       return "outputs after reset";
            2:       return "sync width and period";
            3:       return "line and frame strobes";
            4:       return "black in blanking";
            default: return "fill and colour in active area";
        endcase
    endfunction

    // fill schedule, step is frame bits STEP+5 down to STEP
    function automatic cube_pkg::fill_t expected_fill(input cube_pkg::frame_t f);
        int step;
        step = (int'(f) >> STEP) & 63;
        if (step <= 3)       return cube_pkg::FILL_BLACK;
        else if (step <= 19) return cube_pkg::FILL_WHITE;
        else if (step <= 23) return cube_pkg::FILL_STRIPES;
        else if (step <= 27) return cube_pkg::FILL_XOR;
        else if (step <= 31) return cube_pkg::FILL_BLACK;
        else if (step <= 53) return cube_pkg::FILL_WHITE;
        else if (step <= 57) return cube_pkg::FILL_STRIPES;
        else if (step <= 61) return cube_pkg::FILL_XOR;
        else                 return cube_pkg::FILL_STRIPES;
    endfunction

    function automatic cube_pkg::rgb_t rainbow_color(input int idx);
        case (idx)
            0:       return 6'h31;
            1:       return 6'h15;
            2:       return 6'h0C;
            default: return 6'h2C;
        endcase
    endfunction

    function automatic cube_pkg::vga_out_t expected_out(input int h, input int v,
                                                        input cube_pkg::frame_t f);
        cube_pkg::vga_out_t o;
        int px;
        int py;
        px              = h / (2 * DIV);
        py              = v / DIV;
        o.hsync         = !(h >= H_ACT + H_FP && h < H_ACT + H_FP + H_SY);
        o.vsync         = !(v >= V_ACT + V_FP && v < V_ACT + V_FP + V_SY);
        o.next_vertical = (h == H_TOT - 1);
        o.next_frame    = o.next_vertical && (v == V_TOT - 1);
        case (expected_fill(f))
            cube_pkg::FILL_WHITE:   o.rrggbb = 6'h3F;
            cube_pkg::FILL_STRIPES: o.rrggbb = rainbow_color((py + int'(f[2:1])) % 4);
            cube_pkg::FILL_XOR:     o.rrggbb = cube_pkg::rgb_t'(((px ^ py) & 63) + int'(f[7:2]));
            default:                o.rrggbb = 6'h00;
        endcase
        if (h >= H_ACT || v >= V_ACT) o.rrggbb = 6'h00;
        return o;
    endfunction

    // model steps with the DUT, exp_q is what the pins show after this edge
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            m_h       = 0;
            m_v       = 0;
            m_frame   = '0;
            exp_q     = '0;
            exp_fill  = cube_pkg::FILL_BLACK;
            exp_blank = 1'b1;
        end else begin
            exp_q     = expected_out(m_h, m_v, m_frame);
            exp_fill  = expected_fill(m_frame);
            exp_blank = (m_h >= H_ACT) || (m_v >= V_ACT);
            if (m_h == H_TOT - 1) begin
                m_h = 0;
                if (m_v == V_TOT - 1) begin
                    m_v     = 0;
                    m_frame = m_frame + 1'b1;
                end else begin
                    m_v++;
                end
            end else begin
                m_h++;
            end
        end
    end

    task automatic check_rgb(input string name, input cube_pkg::rgb_t got,
                             input cube_pkg::rgb_t exp, input int b, input int k);
        n_checks++;
        if (got !== exp) begin
            errors[b]++;
            $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, k);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp,
                             input int b, input int k);
        n_checks++;
        if (got !== exp) begin
            errors[b]++;
            $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, k);
        end
    endtask

    // low width and fall-to-fall period of an active-low sync
    task automatic track_sync(input string name, input logic prev, input logic level,
                              input int width, input int period,
                              inout int low_len, inout int since);
        if (since >= 0) since++;
        if (prev && !level) begin
            if (since > 0 && since != period) begin
                errors[2]++;
                $display("%s period was %0d cycles instead of %0d", name, since, period);
            end
            since   = 0;
            low_len = 0;
        end
        if (!level) low_len++;
        if (!prev && level && since >= 0 && low_len != width) begin
            errors[2]++;
            $display("%s stayed low %0d cycles instead of %0d", name, low_len, width);
        end
    endtask

    initial begin : compare
        logic h_prev;
        logic v_prev;
        int   h_low;
        int   h_since;
        int   v_low;
        int   v_since;
        int   nv_count;
        int   nf_count;
        int   total;
        h_low    = 0;
        h_since  = -1;
        v_low    = 0;
        v_since  = -1;
        nv_count = 0;
        nf_count = 0;
        total    = 0;
        wait (rst_ni === 1'b1);
        for (int k = 0; k <= RUN_FRAMES * FRAME_CYCLES; k++) begin
            @(negedge clk_i);
            check_rgb("rrggbb_o", rrggbb_o, exp_q.rrggbb, (k < 2) ? 1 : (exp_blank ? 4 : 5), k);
            check_bit("hsync_o", hsync_o, exp_q.hsync, (k < 2) ? 1 : 2, k);
            check_bit("vsync_o", vsync_o, exp_q.vsync, (k < 2) ? 1 : 2, k);
            check_bit("next_vertical_o", next_vertical_o, exp_q.next_vertical, (k < 2) ? 1 : 3, k);
            check_bit("next_frame_o", next_frame_o, exp_q.next_frame, (k < 2) ? 1 : 3, k);
            // a fill counts once the DUT painted it right
            if (!exp_blank && rrggbb_o === exp_q.rrggbb) begin
                fills_seen[int'(exp_fill)] = 1'b1;
            end
            if (k >= 2) begin
                track_sync("hsync_o", h_prev, hsync_o, H_SY, H_TOT, h_low, h_since);
                track_sync("vsync_o", v_prev, vsync_o, V_SY * H_TOT, FRAME_CYCLES,
                           v_low, v_since);
            end
            h_prev    = hsync_o;
            v_prev    = vsync_o;
            nv_count += int'(next_vertical_o);
            nf_count += int'(next_frame_o);
        end
        if (nv_count != RUN_FRAMES * V_TOT) begin
            errors[3]++;
            $display("next_vertical_o pulsed %0d times, expected %0d", nv_count, RUN_FRAMES * V_TOT);
        end
        if (nf_count != RUN_FRAMES) begin
            errors[3]++;
            $display("next_frame_o pulsed %0d times, expected %0d", nf_count, RUN_FRAMES);
        end
        if (fills_seen != 4'hF) begin
            errors[5]++;
            $display("not all four fills were shown, seen mask %h", fills_seen);
        end
        for (int b = 1; b <= 5; b++) begin
            $display("behavior %0d, %s: %s", b, behavior_text(b),
                     (errors[b] == 0) ? "passed" : "failed");
            total += errors[b];
        end
        $display("checks %0d, errors %0d", n_checks, total);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
